// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [63:0] xlen_t;      // data or address word
    typedef logic [31:0] inst_t;      // raw instruction
    typedef logic [4:0]  reg_idx_t;   // x0..x31
    typedef logic [6:0]  op_class_t;  // one-hot operation class
    typedef logic [3:0]  alu_op_t;    // {inst[30], funct3}

    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_ALU_R = 7'b0110011;
    localparam logic [6:0] OPC_ALU_I = 7'b0010011;

    localparam inst_t INST_EBREAK = 32'h0010_0073;  // whole word, not just opcode

    // bit positions inside op_class_t
    localparam int CLS_LUI    = 0;
    localparam int CLS_AUIPC  = 1;
    localparam int CLS_LOAD   = 2;
    localparam int CLS_STORE  = 3;
    localparam int CLS_ALU_R  = 4;
    localparam int CLS_ALU_I  = 5;
    localparam int CLS_EBREAK = 6;

    localparam alu_op_t ALU_ADD  = 4'b0000;
    localparam alu_op_t ALU_SUB  = 4'b1000;  // alt bit set
    localparam alu_op_t ALU_SLL  = 4'b0001;
    localparam alu_op_t ALU_SLT  = 4'b0010;
    localparam alu_op_t ALU_SLTU = 4'b0011;
    localparam alu_op_t ALU_XOR  = 4'b0100;
    localparam alu_op_t ALU_SRL  = 4'b0101;
    localparam alu_op_t ALU_SRA  = 4'b1101;  // alt bit set
    localparam alu_op_t ALU_OR   = 4'b0110;
    localparam alu_op_t ALU_AND  = 4'b0111;

    // classes that end with a register write
    function automatic logic writes_rd(op_class_t cls);
        return cls[CLS_LUI] | cls[CLS_AUIPC] | cls[CLS_LOAD] | cls[CLS_ALU_R] | cls[CLS_ALU_I];
    endfunction

endpackage

`default_nettype wire

// File: logic/inst_queue.sv
`timescale 1ns/10ps
`default_nettype none

module inst_queue #(
    parameter int QUEUE_DEPTH    = 8,
    parameter int QUEUE_ALM_FULL = 6
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          push,
    input  rv_pkg::xlen_t push_pc,
    input  rv_pkg::inst_t push_inst,
    input  logic          pop,
    output rv_pkg::xlen_t head_pc,
    output rv_pkg::inst_t head_inst,
    output logic          empty,
    output logic          alm_full
);
    import rv_pkg::*;

    localparam int AW = $clog2(QUEUE_DEPTH);
    localparam logic [AW:0] ALM_LVL  = (AW + 1)'(QUEUE_ALM_FULL);
    localparam logic [AW:0] FULL_LVL = (AW + 1)'(QUEUE_DEPTH);

    xlen_t         pc_mem [QUEUE_DEPTH];    // pc and inst share one slot index
    inst_t         inst_mem [QUEUE_DEPTH];
    logic [AW-1:0] wr_ptr;                  // wraps, depth is a power of two
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;                   // occupancy
    logic          do_push;
    logic          do_pop;

    assign empty    = count == '0;
    assign alm_full = count >= ALM_LVL;     // inverted into inst_ready at the top
    assign do_push  = push && !alm_full;    // matches the valid/ready transfer rule
    assign do_pop   = pop && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + {{AW{1'b0}}, do_push} - {{AW{1'b0}}, do_pop};
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr]   <= push_pc;
            inst_mem[wr_ptr] <= push_inst;
        end
    end

    assign head_pc   = pc_mem[rd_ptr];      // head entry, valid when !empty
    assign head_inst = inst_mem[rd_ptr];

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        do_push |-> count != FULL_LVL) else $error("inst_queue push while full");
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty) else $error("inst_queue pop while empty");

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inst_valid,
    input  rv_pkg::xlen_t     inst_pc,
    input  rv_pkg::inst_t     inst_word,
    input  logic              q_empty,
    input  rv_pkg::xlen_t     q_pc,
    input  rv_pkg::inst_t     q_inst,
    input  rv_pkg::xlen_t     rf_rdata_a,
    input  rv_pkg::xlen_t     rf_rdata_b,
    input  logic              ex_wen,
    input  rv_pkg::reg_idx_t  ex_rd,
    input  logic              rs_wen,
    input  rv_pkg::reg_idx_t  rs_rd,
    output logic              q_push,
    output logic              q_pop,
    output rv_pkg::reg_idx_t  rf_raddr_a,
    output rv_pkg::reg_idx_t  rf_raddr_b,
    output logic              id_valid,
    output rv_pkg::op_class_t id_class,
    output rv_pkg::alu_op_t   id_alu_op,
    output rv_pkg::reg_idx_t  id_rd,
    output rv_pkg::xlen_t     id_src_a,
    output rv_pkg::xlen_t     id_src_b,
    output rv_pkg::xlen_t     id_imm,
    output rv_pkg::xlen_t     id_pc,
    output logic              halted
);
    import rv_pkg::*;

    logic       dr_valid;    // decode register holds an instruction
    xlen_t      dr_pc;
    inst_t      dr_inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       hit_a;
    logic       hit_b;
    logic       stall;
    logic       is_ebreak;
    logic       take;        // decode register loads this edge

    assign opcode     = dr_inst[6:0];
    assign funct3     = dr_inst[14:12];
    assign rf_raddr_a = dr_inst[19:15];  // rs1
    assign rf_raddr_b = dr_inst[24:20];  // rs2
    assign id_rd      = dr_inst[11:7];
    assign id_pc      = dr_pc;
    assign id_src_a   = rf_rdata_a;
    assign id_src_b   = rf_rdata_b;

    always_comb begin
        id_class             = '0;              // unknown opcode -> no class
        id_class[CLS_LUI]    = opcode == OPC_LUI;
        id_class[CLS_AUIPC]  = opcode == OPC_AUIPC;
        id_class[CLS_LOAD]   = opcode == OPC_LOAD;
        id_class[CLS_STORE]  = opcode == OPC_STORE;
        id_class[CLS_ALU_R]  = opcode == OPC_ALU_R;
        id_class[CLS_ALU_I]  = opcode == OPC_ALU_I;
        id_class[CLS_EBREAK] = dr_inst == INST_EBREAK;
    end

    // bit 30 is the alternate bit only for R ops and for srai
    assign id_alu_op = {dr_inst[30] & (id_class[CLS_ALU_R] | funct3 == 3'b101), funct3};

    always_comb begin
        if (id_class[CLS_STORE]) begin
            id_imm = {{52{dr_inst[31]}}, dr_inst[31:25], dr_inst[11:7]};  // S form
        end else if (id_class[CLS_LUI] || id_class[CLS_AUIPC]) begin
            id_imm = {{32{dr_inst[31]}}, dr_inst[31:12], 12'b0};          // U form
        end else begin
            id_imm = {{52{dr_inst[31]}}, dr_inst[31:20]};                 // I form, shamt too
        end
    end

    // interlock on producers still in execute or result
    assign uses_rs1 = id_class[CLS_LOAD] | id_class[CLS_STORE] |
                      id_class[CLS_ALU_R] | id_class[CLS_ALU_I];
    assign uses_rs2 = id_class[CLS_STORE] | id_class[CLS_ALU_R];
    assign hit_a = uses_rs1 && rf_raddr_a != '0 &&
                   ((ex_wen && ex_rd == rf_raddr_a) || (rs_wen && rs_rd == rf_raddr_a));
    assign hit_b = uses_rs2 && rf_raddr_b != '0 &&
                   ((ex_wen && ex_rd == rf_raddr_b) || (rs_wen && rs_rd == rf_raddr_b));
    assign stall     = dr_valid && (hit_a || hit_b);
    assign is_ebreak = dr_valid && id_class[CLS_EBREAK];

    assign take     = !stall && !halted && !is_ebreak;  // ebreak parks in the register
    assign q_pop    = take && !q_empty;
    assign q_push   = inst_valid && !(take && q_empty);  // else bypass into decode
    assign id_valid = dr_valid && !stall && !halted;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dr_valid <= 1'b0;
            halted   <= 1'b0;
        end else begin
            if (take) dr_valid <= q_empty ? inst_valid : 1'b1;
            if (is_ebreak) halted <= 1'b1;   // sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dr_pc   <= q_empty ? inst_pc : q_pc;
            dr_inst <= q_empty ? inst_word : q_inst;
        end
    end

    a_class_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        dr_valid |-> $onehot0(id_class)) else $error("decode class not one-hot");

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::reg_idx_t raddr_a,
    input  rv_pkg::reg_idx_t raddr_b,
    input  logic             wen,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::xlen_t    wdata,
    output rv_pkg::xlen_t    rdata_a,
    output rv_pkg::xlen_t    rdata_b
);
    import rv_pkg::*;

    xlen_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin   // x0 never written
            regs[waddr] <= wdata;
        end
    end

    // no write-through, decode interlock covers the write cycle
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

// File: logic/exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              id_valid,
    input  rv_pkg::op_class_t id_class,
    input  rv_pkg::alu_op_t   id_alu_op,
    input  rv_pkg::reg_idx_t  id_rd,
    input  rv_pkg::xlen_t     id_src_a,
    input  rv_pkg::xlen_t     id_src_b,
    input  rv_pkg::xlen_t     id_imm,
    input  rv_pkg::xlen_t     id_pc,
    output logic              ex_valid,
    output logic              ex_wen,
    output rv_pkg::op_class_t ex_class,
    output rv_pkg::reg_idx_t  ex_rd,
    output rv_pkg::xlen_t     ex_result,
    output rv_pkg::xlen_t     ex_store_data
);
    import rv_pkg::*;

    alu_op_t    e_op;
    xlen_t      e_src_a;
    xlen_t      e_src_b;
    xlen_t      e_imm;
    xlen_t      e_pc;
    xlen_t      op_b;       // second ALU operand
    xlen_t      alu_out;
    logic [5:0] shamt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) ex_valid <= 1'b0;
        else ex_valid <= id_valid;   // stall arrives as a bubble
    end

    always_ff @(posedge clk) begin
        ex_class <= id_class;
        ex_rd    <= id_rd;
        e_op     <= id_alu_op;
        e_src_a  <= id_src_a;
        e_src_b  <= id_src_b;
        e_imm    <= id_imm;
        e_pc     <= id_pc;
    end

    assign op_b  = ex_class[CLS_ALU_R] ? e_src_b : e_imm;
    assign shamt = op_b[5:0];    // rv64 shift amount

    always_comb begin
        case (e_op)
            ALU_ADD:  alu_out = e_src_a + op_b;
            ALU_SUB:  alu_out = e_src_a - op_b;
            ALU_SLL:  alu_out = e_src_a << shamt;
            ALU_SLT:  alu_out = {63'b0, $signed(e_src_a) < $signed(op_b)};
            ALU_SLTU: alu_out = {63'b0, e_src_a < op_b};
            ALU_XOR:  alu_out = e_src_a ^ op_b;
            ALU_SRL:  alu_out = e_src_a >> shamt;
            ALU_SRA:  alu_out = xlen_t'($signed(e_src_a) >>> shamt);
            ALU_OR:   alu_out = e_src_a | op_b;
            ALU_AND:  alu_out = e_src_a & op_b;
            default:  alu_out = '0;   // illegal alt-bit combos
        endcase
    end

    always_comb begin
        if (ex_class[CLS_LUI]) ex_result = e_imm;
        else if (ex_class[CLS_AUIPC]) ex_result = e_pc + e_imm;
        else if (ex_class[CLS_LOAD] || ex_class[CLS_STORE]) ex_result = e_src_a + e_imm;  // addr
        else ex_result = alu_out;
    end

    assign ex_wen        = ex_valid && writes_rd(ex_class);
    assign ex_store_data = e_src_b;   // rs2 value for sd

endmodule

`default_nettype wire

// File: logic/result_stage.sv
`timescale 1ns/10ps
`default_nettype none

module result_stage #(
    parameter int DMEM_WORDS = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ex_valid,
    input  rv_pkg::op_class_t ex_class,
    input  rv_pkg::reg_idx_t  ex_rd,
    input  rv_pkg::xlen_t     ex_result,
    input  rv_pkg::xlen_t     ex_store_data,
    output logic              rs_wen,
    output rv_pkg::reg_idx_t  rs_rd,
    output logic              wb_valid,
    output rv_pkg::reg_idx_t  wb_rd,
    output rv_pkg::xlen_t     wb_data
);
    import rv_pkg::*;

    localparam int IW = $clog2(DMEM_WORDS);

    logic          r_valid;
    op_class_t     r_class;
    xlen_t         r_result;     // alu value or load address
    xlen_t         dmem [DMEM_WORDS];
    logic [IW-1:0] st_idx;       // word index of incoming sd
    logic [IW-1:0] ld_idx;       // word index of ld in this stage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) r_valid <= 1'b0;
        else r_valid <= ex_valid;
    end

    always_ff @(posedge clk) begin
        r_class  <= ex_class;
        rs_rd    <= ex_rd;
        r_result <= ex_result;
    end

    // byte address -> dword index, wraps modulo DMEM_WORDS
    assign st_idx = ex_result[3 +: IW];
    assign ld_idx = r_result[3 +: IW];

    always_ff @(posedge clk) begin
        if (ex_valid && ex_class[CLS_STORE]) dmem[st_idx] <= ex_store_data;  // on entry
    end

    assign rs_wen   = r_valid && writes_rd(r_class);   // still in flight for decode
    assign wb_valid = rs_wen && rs_rd != '0;           // x0 writes dropped here
    assign wb_rd    = rs_rd;
    assign wb_data  = r_class[CLS_LOAD] ? dmem[ld_idx] : r_result;

    a_mem_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid && (ex_class[CLS_LOAD] || ex_class[CLS_STORE]) |-> ex_result[2:0] == 3'b000)
        else $error("misaligned ld/sd address %h", ex_result);

endmodule

`default_nettype wire

// File: logic/core_slice_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_slice_top #(
    parameter int QUEUE_DEPTH    = 8,
    parameter int QUEUE_ALM_FULL = 6,
    parameter int DMEM_WORDS     = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             inst_valid,
    input  rv_pkg::xlen_t    inst_pc,
    input  rv_pkg::inst_t    inst_word,
    output logic             inst_ready,
    output logic             wb_valid,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::xlen_t    wb_data,
    output logic             halted
);
    import rv_pkg::*;

    logic      q_push;
    logic      q_pop;
    logic      q_empty;
    logic      q_alm_full;
    xlen_t     q_pc;
    inst_t     q_inst;
    reg_idx_t  rf_raddr_a;
    reg_idx_t  rf_raddr_b;
    xlen_t     rf_rdata_a;
    xlen_t     rf_rdata_b;
    logic      id_valid;
    op_class_t id_class;
    alu_op_t   id_alu_op;
    reg_idx_t  id_rd;
    xlen_t     id_src_a;
    xlen_t     id_src_b;
    xlen_t     id_imm;
    xlen_t     id_pc;
    logic      ex_valid;
    logic      ex_wen;
    op_class_t ex_class;
    reg_idx_t  ex_rd;
    xlen_t     ex_result;
    xlen_t     ex_store_data;
    logic      rs_wen;
    reg_idx_t  rs_rd;

    assign inst_ready = !q_alm_full;   // headroom for in-flight transfers

    inst_queue #(
        .QUEUE_DEPTH    (QUEUE_DEPTH),
        .QUEUE_ALM_FULL (QUEUE_ALM_FULL)
    ) u_queue (
        .clk (clk), .rst_n (rst_n),
        .push (q_push), .push_pc (inst_pc), .push_inst (inst_word), .pop (q_pop),
        .head_pc (q_pc), .head_inst (q_inst), .empty (q_empty), .alm_full (q_alm_full)
    );

    decode_stage u_decode (
        .clk (clk), .rst_n (rst_n),
        .inst_valid (inst_valid), .inst_pc (inst_pc), .inst_word (inst_word),
        .q_empty (q_empty), .q_pc (q_pc), .q_inst (q_inst),
        .rf_rdata_a (rf_rdata_a), .rf_rdata_b (rf_rdata_b),
        .ex_wen (ex_wen), .ex_rd (ex_rd), .rs_wen (rs_wen), .rs_rd (rs_rd),
        .q_push (q_push), .q_pop (q_pop),
        .rf_raddr_a (rf_raddr_a), .rf_raddr_b (rf_raddr_b),
        .id_valid (id_valid), .id_class (id_class), .id_alu_op (id_alu_op), .id_rd (id_rd),
        .id_src_a (id_src_a), .id_src_b (id_src_b), .id_imm (id_imm), .id_pc (id_pc),
        .halted (halted)
    );

    reg_file u_rf (
        .clk (clk), .rst_n (rst_n),
        .raddr_a (rf_raddr_a), .raddr_b (rf_raddr_b),
        .wen (wb_valid), .waddr (wb_rd), .wdata (wb_data),
        .rdata_a (rf_rdata_a), .rdata_b (rf_rdata_b)
    );

    exec_unit u_exec (
        .clk (clk), .rst_n (rst_n),
        .id_valid (id_valid), .id_class (id_class), .id_alu_op (id_alu_op), .id_rd (id_rd),
        .id_src_a (id_src_a), .id_src_b (id_src_b), .id_imm (id_imm), .id_pc (id_pc),
        .ex_valid (ex_valid), .ex_wen (ex_wen), .ex_class (ex_class), .ex_rd (ex_rd),
        .ex_result (ex_result), .ex_store_data (ex_store_data)
    );

    result_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_result (
        .clk (clk), .rst_n (rst_n),
        .ex_valid (ex_valid), .ex_class (ex_class), .ex_rd (ex_rd),
        .ex_result (ex_result), .ex_store_data (ex_store_data),
        .rs_wen (rs_wen), .rs_rd (rs_rd),
        .wb_valid (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data)
    );

endmodule

`default_nettype wire

// File: verif/tb_core_slice.sv
`timescale 1ns/10ps
`default_nettype none

module tb_core_slice;
    import rv_pkg::*;

    localparam int NUM_TESTS  = 6;
    localparam int DMEM_WORDS = 64;

    logic     clk;
    logic     rst_n;
    logic     inst_valid;
    xlen_t    inst_pc;
    inst_t    inst_word;
    logic     inst_ready;
    logic     wb_valid;
    reg_idx_t wb_rd;
    xlen_t    wb_data;
    logic     halted;

    logic [63:0] rng_state = 64'd12637;
    inst_t       prog [$];                  // all tests back to back
    int          test_start [NUM_TESTS];
    int          test_len [NUM_TESTS];
    string       names [NUM_TESTS] = '{"alu and lui/auipc", "dependent chains", "sd/ld",
                                       "held valid", "ebreak halt", "x0 handling"};
    xlen_t       m_regs [32];               // model register file
    xlen_t       m_dmem [DMEM_WORDS];       // model data memory, kept across resets like the DUT
    logic        m_halted;
    reg_idx_t    exp_rd [$];                // expected write-backs in order
    xlen_t       exp_data [$];
    int          errors = 0;
    int          wb_count;
    int          wb_total = 0;
    int          stall_cycles;              // valid high while ready low
    int          total_insts = 0;

    core_slice_top #(
        .QUEUE_DEPTH    (8),
        .QUEUE_ALM_FULL (6),
        .DMEM_WORDS     (DMEM_WORDS)
    ) dut0 (
        .clk (clk), .rst_n (rst_n),
        .inst_valid (inst_valid), .inst_pc (inst_pc), .inst_word (inst_word),
        .inst_ready (inst_ready),
        .wb_valid (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data),
        .halted (halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;              // 40 ns period
    end

    function automatic logic [63:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    function automatic reg_idx_t rand_reg();
        logic [63:0] r;
        r = xorshift();
        return {1'b0, r[3:0]} + 5'd1;        // x1..x16, keeps dependencies frequent
    endfunction

    function automatic inst_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], OPC_STORE};  // sd
    endfunction

    function automatic inst_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // random register or immediate alu op, alt bit only where the isa has one
    function automatic inst_t rand_alu(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
        logic [63:0] r;
        logic [2:0]  f3;
        logic        alt;
        r   = xorshift();
        f3  = r[2:0];
        alt = r[3] && (f3 == 3'b000 || f3 == 3'b101);
        if (r[4]) return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_ALU_R};
        if (f3 == 3'b001 || f3 == 3'b101)
            return enc_i({1'b0, alt, 4'b0, r[13:8]}, rs1, f3, rd, OPC_ALU_I);
        return enc_i(r[27:16], rs1, f3, rd, OPC_ALU_I);
    endfunction

    function automatic xlen_t alu_ref(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
        logic [5:0] sh;
        sh = b[5:0];                         // rv64 shift amount
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'd3: return (a < b) ? 64'd1 : 64'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? xlen_t'($signed(a) >>> sh) : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // executes one instruction on the model, queues the write-back it should cause
    function automatic void ref_exec(xlen_t pc, inst_t inst);
        logic [2:0] f3;
        reg_idx_t   rd;
        xlen_t      a;
        xlen_t      b;
        xlen_t      imm_i;
        xlen_t      addr;
        xlen_t      res;
        logic       wr;
        f3    = inst[14:12];
        rd    = inst[11:7];
        a     = m_regs[inst[19:15]];         // m_regs[0] stays zero
        b     = m_regs[inst[24:20]];
        imm_i = {{52{inst[31]}}, inst[31:20]};
        res   = '0;
        wr    = 1'b1;
        if (m_halted) return;                // nothing issues after ebreak
        if (inst == INST_EBREAK) begin
            m_halted = 1'b1;
            return;
        end
        case (inst[6:0])
            OPC_LUI:   res = {{32{inst[31]}}, inst[31:12], 12'b0};
            OPC_AUIPC: res = pc + {{32{inst[31]}}, inst[31:12], 12'b0};
            OPC_LOAD:  res = m_dmem[(a + imm_i) >> 3 & 64'(DMEM_WORDS - 1)];
            OPC_STORE: begin
                addr = a + {{52{inst[31]}}, inst[31:25], inst[11:7]};
                m_dmem[addr >> 3 & 64'(DMEM_WORDS - 1)] = b;
                wr = 1'b0;
            end
            OPC_ALU_R: res = alu_ref(f3, inst[30], a, b);
            OPC_ALU_I: res = alu_ref(f3, inst[30] && f3 == 3'b101, a, imm_i);  // srai only
            default:   wr = 1'b0;
        endcase
        if (wr && rd != 5'd0) begin
            m_regs[rd] = res;
            exp_rd.push_back(rd);
            exp_data.push_back(res);
        end
    endfunction

    task automatic check_val(string what, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic build_programs();
        logic [63:0] r;
        reg_idx_t    rd;
        reg_idx_t    prev;
        reg_idx_t    prev2;
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_start[t] = prog.size();
            for (int i = 1; i <= 8; i++) begin       // seed x1..x8
                r  = xorshift();
                rd = reg_idx_t'(i);
                prog.push_back(enc_u(r[19:0], rd, OPC_LUI));
                prog.push_back(enc_i(r[31:20], rd, 3'b000, rd, OPC_ALU_I));
            end
            prev  = 5'd1;
            prev2 = 5'd2;
            for (int i = 0; i < 40; i++) begin
                r  = xorshift();
                rd = rand_reg();
                case (t)
                    0: begin
                        if (r[2:0] == 3'd0) prog.push_back(enc_u(r[31:12], rd, OPC_LUI));
                        else if (r[2:0] == 3'd1) prog.push_back(enc_u(r[31:12], rd, OPC_AUIPC));
                        else prog.push_back(rand_alu(rd, rand_reg(), rand_reg()));
                    end
                    1: prog.push_back(rand_alu(rd, prev, prev2));   // last two results
                    2: begin
                        prog.push_back(enc_s({3'b0, r[5:0], 3'b0}, rand_reg(), 5'd0));
                        prog.push_back(enc_i({3'b0, r[5:0], 3'b0}, 5'd0, 3'b011, rd, OPC_LOAD));
                        prog.push_back(rand_alu(rand_reg(), rd, rand_reg()));  // ld result used
                    end
                    3: prog.push_back(rand_alu(rd, prev, prev));    // one long chain
                    4: begin
                        if (i == 20) prog.push_back(INST_EBREAK);
                        else if (i < 25) prog.push_back(rand_alu(rd, rand_reg(), rand_reg()));
                    end
                    default: begin
                        if (r[1:0] == 2'd0) prog.push_back(rand_alu(5'd0, rand_reg(), rand_reg()));
                        else if (r[1:0] == 2'd1) prog.push_back(rand_alu(rd, 5'd0, rand_reg()));
                        else if (r[1:0] == 2'd2) prog.push_back(rand_alu(rd, rand_reg(), 5'd0));
                        else prog.push_back(enc_u(r[31:12], 5'd0, OPC_LUI));
                    end
                endcase
                prev2 = prev;
                prev  = rd;
            end
            test_len[t] = prog.size() - test_start[t];
        end
        total_insts = prog.size();
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        foreach (m_regs[i]) m_regs[i] = '0;
        m_halted     = 1'b0;
        wb_count     = 0;
        stall_cycles = 0;
        exp_rd.delete();
        exp_data.delete();
        rst_n = 1'b1;
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_inst(xlen_t pc, inst_t inst);
        inst_valid = 1'b1;
        inst_pc    = pc;
        inst_word  = inst;
        while (!inst_ready) @(negedge clk);  // ready only moves on rising edges
        @(negedge clk);
    endtask

    task automatic run_test(int t);
        logic [63:0] r;
        xlen_t       pc_base;
        xlen_t       pc;
        int          err0;
        int          exp_count;
        err0 = errors;
        reset_dut();
        check_val("halted after reset", 64'(halted), 64'd0);
        check_val("inst_ready after reset", 64'(inst_ready), 64'd1);
        check_val("wb_valid after reset", 64'(wb_valid), 64'd0);
        r       = xorshift();
        pc_base = {r[63:2], 2'b00};
        for (int i = 0; i < test_len[t]; i++) begin
            pc = pc_base + 64'(4 * i);
            ref_exec(pc, prog[test_start[t] + i]);
        end
        exp_count = exp_data.size();         // model's write-back count
        for (int i = 0; i < test_len[t]; i++) begin
            pc = pc_base + 64'(4 * i);
            send_inst(pc, prog[test_start[t] + i]);
        end
        inst_valid = 1'b0;
        if (t == 4) begin
            wait (halted);
            repeat (50) @(negedge clk);      // anything behind ebreak would show up here
            check_val("halted", 64'(halted), 64'd1);
        end else begin
            wait (wb_count == exp_count);
            repeat (10) @(negedge clk);      // room for extra write-backs
        end
        @(posedge clk);                      // counters move on the falling edge
        check_val("write-back count", 64'(wb_count), 64'(exp_count));
        if (t == 3) check_val("ready fell under back-pressure", 64'(stall_cycles > 0), 64'd1);
        wb_total += wb_count;
        $display("Test %0d (%s): %0d instructions, %0d write-backs, %0d errors",
                 t, names[t], test_len[t], wb_count, errors - err0);
    endtask

    // compare process, outputs are stable on the falling edge
    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            wb_count++;
            if (exp_rd.size() == 0) begin
                $display("Unexpected write-back to x%0d at %0t ns", wb_rd, $time);
                errors++;
            end else begin
                check_val("wb_rd", 64'(wb_rd), 64'(exp_rd.pop_front()));
                check_val("wb_data", wb_data, exp_data.pop_front());
            end
        end
        if (rst_n && inst_valid && !inst_ready) stall_cycles++;
    end

    initial begin
        wait (total_insts > 0);
        repeat (total_insts * 20) @(posedge clk);
        $display("Simulation timed out before all tests finished");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst_pc    = '0;
        inst_word  = '0;
        build_programs();
        for (int t = 0; t < NUM_TESTS; t++) run_test(t);
        $display("%0d tests, %0d write-backs checked, %0d errors", NUM_TESTS, wb_total, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
logic/rv_pkg.sv
logic/inst_queue.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/result_stage.sv
logic/core_slice_top.sv
verif/tb_core_slice.sv

// File: Makefile
TOP = tb_core_slice

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
